/* build.f */
+incdir+test
common/tinyrv1_pkg.sv
common/mem_sys_pkg.sv
proc/proc_fetch.sv
proc/proc_core.sv
src/mem_arbiter.sv
src/unified_mem.sv
src/proc_system.sv
test/proc_system_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module proc_system_tb \
  -f build.f --Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vproc_system_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qxF 'All tests passed!'; then
  exit 0
fi
exit 1

/* test/tinyrv1_model.svh */
`ifndef TINYRV1_MODEL_SVH
`define TINYRV1_MODEL_SVH

  // ======================================================================
  // Golden TinyRV1 model
  // ======================================================================

  localparam int MODEL_AW = 10;

  word_t model_mem [2**MODEL_AW];
  word_t model_rf  [32];
  addr_t model_pc;
  logic  model_halted;
  int    model_retired;

  // Instruction encoders
  function automatic word_t addi_word(reg_idx_t rd, reg_idx_t rs1, int imm);
    return {imm[11:0], rs1, F3_ADD, rd, OP_IMM};
  endfunction

  function automatic word_t add_word(reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
    return {F7_ADD, rs2, rs1, F3_ADD, rd, OP_REG};
  endfunction

  function automatic word_t mul_word(reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
    return {F7_MUL, rs2, rs1, F3_MUL, rd, OP_REG};
  endfunction

  function automatic word_t lw_word(reg_idx_t rd, reg_idx_t rs1, int imm);
    return {imm[11:0], rs1, F3_LW, rd, OP_LOAD};
  endfunction

  function automatic word_t sw_word(reg_idx_t rs2, reg_idx_t rs1, int imm);
    return {imm[11:5], rs2, rs1, F3_SW, imm[4:0], OP_STORE};
  endfunction

  function automatic word_t bne_word(reg_idx_t rs1, reg_idx_t rs2, int off);
    logic [12:0] b;
    b = off[12:0];
    return {b[12], b[10:5], rs2, rs1, F3_BNE, b[4:1], b[11], OP_BRANCH};
  endfunction

  // Byte address to model word slot
  function automatic int word_index(addr_t addr);
    return int'(addr[MODEL_AW+1:2]);
  endfunction

  function automatic void init_model();
    for (int r = 0; r < 32; r++) begin
      model_rf[r] = '0;
    end
    model_retired = 0;
  endfunction

  // Registers survive a restart, like the core's register file
  function automatic void restart_model();
    model_pc     = RESET_PC;
    model_halted = 1'b0;
  endfunction

  // Execute one instruction; returns its address and trace value
  function automatic void step_model(output addr_t pc_o, output word_t data_o);
    word_t    inst;
    word_t    a;
    word_t    b;
    word_t    imm_i;
    word_t    imm_s;
    word_t    imm_b;
    word_t    res;
    addr_t    next_pc;
    reg_idx_t rd;
    logic     writes_rd;
    inst      = model_mem[word_index(model_pc)];
    rd        = inst[11:7];
    a         = model_rf[inst[19:15]];
    b         = model_rf[inst[24:20]];
    imm_i     = {{20{inst[31]}}, inst[31:20]};
    imm_s     = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    imm_b     = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    res       = '0;
    writes_rd = 1'b0;
    next_pc   = model_pc + 32'd4;
    case (inst[6:0])
      OP_IMM: begin
        res       = a + imm_i;
        writes_rd = 1'b1;
      end
      OP_REG: begin
        res       = (inst[31:25] == F7_MUL) ? a * b : a + b;
        writes_rd = 1'b1;
      end
      OP_LOAD: begin
        res       = model_mem[word_index(a + imm_i)];
        writes_rd = 1'b1;
      end
      OP_STORE: begin
        res = b;
        model_mem[word_index(a + imm_s)] = b;
      end
      OP_BRANCH: begin
        if (a != b) begin
          next_pc = model_pc + imm_b;
          // Branch to itself marks the end of a program
          if (imm_b == '0) begin
            model_halted = 1'b1;
          end
        end
      end
      default: res = 'x;
    endcase
    if (writes_rd && rd != '0) begin
      model_rf[rd] = res;
    end
    pc_o          = model_pc;
    data_o        = res;
    model_pc      = next_pc;
    model_retired = model_retired + 1;
  endfunction

`endif

/* test/proc_system_tb.sv */
`timescale 1ns/1ps

module proc_system_tb;

  import tinyrv1_pkg::*;

  localparam int MEM_AW    = 10;
  localparam int DATA_BASE = 512;
  // 23 programs each well under 120 cycles of load and run
  localparam int MAX_CYCLES = 4000;

  logic  clk;
  logic  rst;
  logic  host_val;
  logic  host_we;
  addr_t host_addr;
  word_t host_wdata;
  word_t host_rdata;
  logic  trace_val;
  addr_t trace_addr;
  word_t trace_inst;
  word_t trace_data;

  `include "tinyrv1_model.svh"

  word_t prog [$];
  word_t host_expect;
  addr_t exp_addr;
  word_t exp_inst;
  word_t exp_data;
  int    trace_errors;
  int    host_errors;
  int    reset_errors;
  int    cycles;
  int    seed;

  proc_system #(.MEM_AW(MEM_AW)) proc_system_inst (
    .clk        (clk),
    .rst        (rst),
    .host_val   (host_val),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata),
    .trace_val  (trace_val),
    .trace_addr (trace_addr),
    .trace_inst (trace_inst),
    .trace_data (trace_data)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  // One model step per retired instruction at mid-cycle
  always @(negedge clk) begin
    if (trace_val && !rst) begin
      exp_inst = model_mem[word_index(model_pc)];
      step_model(exp_addr, exp_data);
    end
  end

  // ======================================================================
  // Checks
  // ======================================================================

  assert property (@(posedge clk) disable iff (rst) trace_val |-> trace_addr === exp_addr)
    else begin
      trace_errors++;
      $display("FAILED trace_addr: got %h, expected %h", $sampled(trace_addr),
               $sampled(exp_addr));
    end

  assert property (@(posedge clk) disable iff (rst) trace_val |-> trace_inst === exp_inst)
    else begin
      trace_errors++;
      $display("FAILED trace_inst: got %h, expected %h", $sampled(trace_inst),
               $sampled(exp_inst));
    end

  assert property (@(posedge clk) disable iff (rst) trace_val |-> trace_data === exp_data)
    else begin
      trace_errors++;
      $display("FAILED trace_data: got %h, expected %h", $sampled(trace_data),
               $sampled(exp_data));
    end

  assert property (@(posedge clk) host_val && !host_we |-> host_rdata === host_expect)
    else begin
      host_errors++;
      $display("FAILED host_rdata: got %h, expected %h", $sampled(host_rdata),
               $sampled(host_expect));
    end

  // Nothing retires during reset or in the cycle right after it
  assert property (@(posedge clk) rst |=> !trace_val)
    else begin
      reset_errors++;
      $display("Instruction retired during or right after reset");
    end

  // ======================================================================
  // Stimulus helpers
  // ======================================================================

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic host_write(input addr_t addr, input word_t data);
    host_val   = 1'b1;
    host_we    = 1'b1;
    host_addr  = addr;
    host_wdata = data;
    model_mem[word_index(addr)] = data;
    next_cycle();
  endtask

  task automatic host_read(input addr_t addr);
    host_val    = 1'b1;
    host_we     = 1'b0;
    host_addr   = addr;
    host_expect = model_mem[word_index(addr)];
    next_cycle();
  endtask

  task automatic host_idle();
    host_val = 1'b0;
    host_we  = 1'b0;
  endtask

  // Reset spans the first two writes; host keeps fetch out until the image is in
  task automatic load_program();
    rst = 1'b1;
    restart_model();
    foreach (prog[i]) begin
      host_write(addr_t'(4 * i), prog[i]);
      if (i == 1) begin
        rst = 1'b0;
      end
    end
    host_idle();
  endtask

  task automatic wait_halt();
    while (!model_halted) begin
      next_cycle();
    end
  endtask

  task automatic append_halt();
    prog.push_back(addi_word(5'd31, 5'd0, 1));
    prog.push_back(bne_word(5'd31, 5'd0, 0));
  endtask

  task automatic build_chain_program();
    prog.delete();
    prog.push_back(addi_word(5'd1, 5'd0, 5));
    prog.push_back(addi_word(5'd2, 5'd1, 7));
    prog.push_back(add_word(5'd3, 5'd1, 5'd2));
    prog.push_back(mul_word(5'd4, 5'd3, 5'd2));
    prog.push_back(add_word(5'd5, 5'd4, 5'd4));
    prog.push_back(mul_word(5'd6, 5'd5, 5'd3));
    prog.push_back(addi_word(5'd7, 5'd6, -3));
    append_halt();
  endtask

  // Loads and stores hitting the same few words
  task automatic build_mem_program();
    prog.delete();
    prog.push_back(addi_word(5'd10, 5'd0, DATA_BASE));
    prog.push_back(addi_word(5'd1, 5'd0, 11));
    prog.push_back(addi_word(5'd2, 5'd0, 22));
    prog.push_back(sw_word(5'd1, 5'd10, 0));
    prog.push_back(sw_word(5'd2, 5'd10, 4));
    prog.push_back(lw_word(5'd3, 5'd10, 0));
    prog.push_back(lw_word(5'd4, 5'd10, 4));
    prog.push_back(add_word(5'd5, 5'd3, 5'd4));
    prog.push_back(sw_word(5'd5, 5'd10, 0));
    prog.push_back(lw_word(5'd6, 5'd10, 0));
    prog.push_back(mul_word(5'd7, 5'd6, 5'd4));
    prog.push_back(sw_word(5'd7, 5'd10, 8));
    prog.push_back(lw_word(5'd8, 5'd10, 8));
    prog.push_back(sw_word(5'd8, 5'd10, 4));
    append_halt();
  endtask

  task automatic build_branch_program();
    prog.delete();
    prog.push_back(addi_word(5'd1, 5'd0, 3));
    prog.push_back(addi_word(5'd2, 5'd0, 3));
    prog.push_back(bne_word(5'd1, 5'd2, 8));
    prog.push_back(addi_word(5'd3, 5'd0, 1));
    prog.push_back(bne_word(5'd1, 5'd3, 8));
    // Skipped by the taken bne above
    prog.push_back(addi_word(5'd4, 5'd0, 99));
    prog.push_back(addi_word(5'd5, 5'd0, 7));
    prog.push_back(addi_word(5'd6, 5'd0, 3));
    prog.push_back(addi_word(5'd6, 5'd6, -1));
    prog.push_back(bne_word(5'd6, 5'd0, -4));
    append_halt();
  endtask

  task automatic build_random_program();
    int       kind;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    prog.delete();
    // Give x1..x7 defined values first
    for (int r = 1; r < 8; r++) begin
      prog.push_back(addi_word(reg_idx_t'(r), 5'd0, $random(seed)));
    end
    repeat (10) begin
      kind = int'({$random(seed)} % 3);
      rd   = reg_idx_t'(1 + {$random(seed)} % 7);
      rs1  = reg_idx_t'(1 + {$random(seed)} % 7);
      rs2  = reg_idx_t'(1 + {$random(seed)} % 7);
      case (kind)
        0:       prog.push_back(add_word(rd, rs1, rs2));
        1:       prog.push_back(mul_word(rd, rs1, rs2));
        default: prog.push_back(addi_word(rd, rs1, $random(seed)));
      endcase
    end
    append_halt();
  endtask

  // ======================================================================
  // Test sequence
  // ======================================================================

  initial begin
    int target;
    rst          = 1'b1;
    host_val     = 1'b0;
    host_we      = 1'b0;
    host_addr    = '0;
    host_wdata   = '0;
    host_expect  = '0;
    exp_addr     = '0;
    exp_inst     = '0;
    exp_data     = '0;
    trace_errors = 0;
    host_errors  = 0;
    reset_errors = 0;
    cycles       = 0;
    seed         = 85;
    init_model();

    // Dependent chain with the host taking the memory for a while mid-run
    build_chain_program();
    load_program();
    target = model_retired + 3;
    while (model_retired < target) begin
      next_cycle();
    end
    for (int i = 0; i < 6; i++) begin
      host_read(addr_t'(4 * i));
    end
    host_idle();
    wait_halt();

    build_mem_program();
    load_program();
    wait_halt();
    for (int i = 0; i < 3; i++) begin
      host_read(addr_t'(DATA_BASE + 4 * i));
    end
    host_idle();

    build_branch_program();
    load_program();
    wait_halt();

    for (int n = 0; n < 20; n++) begin
      build_random_program();
      load_program();
      wait_halt();
    end
    next_cycle();
    next_cycle();

    $display("Retired %0d instructions; errors: %0d trace, %0d host, %0d reset",
             model_retired, trace_errors, host_errors, reset_errors);
    if (trace_errors + host_errors + reset_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* src/proc_system.sv */
`timescale 1ns/1ps

module proc_system #(
  parameter int MEM_AW = 10
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                host_val,
  input  logic                host_we,
  input  tinyrv1_pkg::addr_t  host_addr,
  input  tinyrv1_pkg::word_t  host_wdata,
  output tinyrv1_pkg::word_t  host_rdata,
  output logic                trace_val,
  output tinyrv1_pkg::addr_t  trace_addr,
  output tinyrv1_pkg::word_t  trace_inst,
  output tinyrv1_pkg::word_t  trace_data
);

  import tinyrv1_pkg::*;
  import mem_sys_pkg::*;

  // ======================================================================
  // Interconnect
  // ======================================================================

  logic     stall_d, redirect_val;
  addr_t    redirect_pc;
  logic     fd_val;
  addr_t    fd_pc;
  word_t    fd_inst;

  logic     imem_val, imem_gnt;
  addr_t    imem_addr;
  word_t    imem_rdata;

  logic     dmem_val, dmem_we, dmem_gnt;
  addr_t    dmem_addr;
  word_t    dmem_wdata, dmem_rdata;

  logic     mem_we;
  mem_idx_t mem_idx;
  word_t    mem_wdata, mem_rdata;

  proc_fetch fetch_inst (
    .clk          (clk),
    .rst          (rst),
    .stall_d      (stall_d),
    .redirect_val (redirect_val),
    .redirect_pc  (redirect_pc),
    .imem_gnt     (imem_gnt),
    .imem_rdata   (imem_rdata),
    .imem_val     (imem_val),
    .imem_addr    (imem_addr),
    .fd_val       (fd_val),
    .fd_pc        (fd_pc),
    .fd_inst      (fd_inst)
  );

  proc_core core_inst (
    .clk          (clk),
    .rst          (rst),
    .fd_val       (fd_val),
    .fd_pc        (fd_pc),
    .fd_inst      (fd_inst),
    .stall_d      (stall_d),
    .redirect_val (redirect_val),
    .redirect_pc  (redirect_pc),
    .dmem_val     (dmem_val),
    .dmem_we      (dmem_we),
    .dmem_addr    (dmem_addr),
    .dmem_wdata   (dmem_wdata),
    .dmem_gnt     (dmem_gnt),
    .dmem_rdata   (dmem_rdata),
    .trace_val    (trace_val),
    .trace_addr   (trace_addr),
    .trace_inst   (trace_inst),
    .trace_data   (trace_data)
  );

  mem_arbiter #(.MEM_AW(MEM_AW)) arbiter_inst (
    .host_val   (host_val),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata),
    .dmem_val   (dmem_val),
    .dmem_we    (dmem_we),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_gnt   (dmem_gnt),
    .dmem_rdata (dmem_rdata),
    .imem_val   (imem_val),
    .imem_addr  (imem_addr),
    .imem_gnt   (imem_gnt),
    .imem_rdata (imem_rdata),
    .mem_we     (mem_we),
    .mem_idx    (mem_idx),
    .mem_wdata  (mem_wdata),
    .mem_rdata  (mem_rdata)
  );

  unified_mem #(.MEM_AW(MEM_AW)) mem_inst (
    .clk   (clk),
    .we    (mem_we),
    .idx   (mem_idx),
    .wdata (mem_wdata),
    .rdata (mem_rdata)
  );

endmodule

/* src/unified_mem.sv */
`timescale 1ns/1ps

module unified_mem #(
  parameter int MEM_AW = 10
) (
  input  logic                  clk,
  input  logic                  we,
  input  mem_sys_pkg::mem_idx_t idx,
  input  tinyrv1_pkg::word_t    wdata,
  output tinyrv1_pkg::word_t    rdata
);

  import tinyrv1_pkg::*;

  localparam int DEPTH = 2 ** MEM_AW;

  word_t mem [DEPTH];
  logic  in_range;

  // Indices past the array read as zero and drop writes
  assign in_range = (idx >> MEM_AW) == '0;

  // Combinational read
  assign rdata = in_range ? mem[idx[MEM_AW-1:0]] : '0;

  // Write lands at the edge, visible to the next cycle's read
  always_ff @(posedge clk) begin
    if (we && in_range) begin
      mem[idx[MEM_AW-1:0]] <= wdata;
    end
  end

endmodule

/* src/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter #(
  parameter int MEM_AW = 10
) (
  input  logic                  host_val,
  input  logic                  host_we,
  input  tinyrv1_pkg::addr_t    host_addr,
  input  tinyrv1_pkg::word_t    host_wdata,
  output tinyrv1_pkg::word_t    host_rdata,
  input  logic                  dmem_val,
  input  logic                  dmem_we,
  input  tinyrv1_pkg::addr_t    dmem_addr,
  input  tinyrv1_pkg::word_t    dmem_wdata,
  output logic                  dmem_gnt,
  output tinyrv1_pkg::word_t    dmem_rdata,
  input  logic                  imem_val,
  input  tinyrv1_pkg::addr_t    imem_addr,
  output logic                  imem_gnt,
  output tinyrv1_pkg::word_t    imem_rdata,
  output logic                  mem_we,
  output mem_sys_pkg::mem_idx_t mem_idx,
  output tinyrv1_pkg::word_t    mem_wdata,
  input  tinyrv1_pkg::word_t    mem_rdata
);

  import tinyrv1_pkg::*;
  import mem_sys_pkg::*;

  req_src_e winner;
  addr_t    sel_addr;
  logic     host_gnt;

  // Fixed priority: host, data, fetch
  always_comb begin
    if (host_val)      winner = SRC_HOST;
    else if (dmem_val) winner = SRC_DATA;
    else if (imem_val) winner = SRC_FETCH;
    else               winner = SRC_NONE;
  end

  assign host_gnt = (winner == SRC_HOST);
  assign dmem_gnt = (winner == SRC_DATA);
  assign imem_gnt = (winner == SRC_FETCH);

  always_comb begin
    case (winner)
      SRC_HOST:  begin sel_addr = host_addr; mem_we = host_we; mem_wdata = host_wdata; end
      SRC_DATA:  begin sel_addr = dmem_addr; mem_we = dmem_we; mem_wdata = dmem_wdata; end
      SRC_FETCH: begin sel_addr = imem_addr; mem_we = 1'b0;    mem_wdata = '0;         end
      default:   begin sel_addr = '0;        mem_we = 1'b0;    mem_wdata = '0;         end
    endcase
  end

  // Byte address to word index
  assign mem_idx = mem_idx_t'(sel_addr[MEM_AW+1:2]);

  assign host_rdata = host_gnt ? mem_rdata : '0;
  assign dmem_rdata = dmem_gnt ? mem_rdata : '0;
  assign imem_rdata = imem_gnt ? mem_rdata : '0;

  always_comb begin
    assert final ($onehot0({host_gnt, dmem_gnt, imem_gnt}))
      else $error("more than one memory grant");
    assert final ((!dmem_gnt || dmem_val) && (!imem_gnt || imem_val) && (!host_gnt || host_val))
      else $error("grant without a matching request");
  end

endmodule

/* proc/proc_core.sv */
`timescale 1ns/1ps

module proc_core (
  input  logic                clk,
  input  logic                rst,
  input  logic                fd_val,
  input  tinyrv1_pkg::addr_t  fd_pc,
  input  tinyrv1_pkg::word_t  fd_inst,
  output logic                stall_d,
  output logic                redirect_val,
  output tinyrv1_pkg::addr_t  redirect_pc,
  output logic                dmem_val,
  output logic                dmem_we,
  output tinyrv1_pkg::addr_t  dmem_addr,
  output tinyrv1_pkg::word_t  dmem_wdata,
  input  logic                dmem_gnt,
  input  tinyrv1_pkg::word_t  dmem_rdata,
  output logic                trace_val,
  output tinyrv1_pkg::addr_t  trace_addr,
  output tinyrv1_pkg::word_t  trace_inst,
  output tinyrv1_pkg::word_t  trace_data
);

  import tinyrv1_pkg::*;

  typedef enum logic [2:0] {
    DEC_NOP, DEC_ADDI, DEC_ADD, DEC_MUL, DEC_LW, DEC_SW, DEC_BNE
  } op_e;

  // Pipeline registers
  logic     x_val, m_val, w_val;
  op_e      x_op, m_op;
  addr_t    x_pc, m_pc, w_pc;
  word_t    x_inst, m_inst, w_inst;
  reg_idx_t x_rd, m_rd, w_rd;
  logic     x_wen, m_wen, w_wen;
  word_t    x_a, x_b, x_imm;
  word_t    m_alu, m_sdata, w_data;

  word_t rf [NUM_REGS];

  // ======================================================================
  // Decode
  // ======================================================================

  opcode_t  d_opcode;
  funct3_t  d_f3;
  funct7_t  d_f7;
  reg_idx_t d_rs1, d_rs2, d_rd;
  word_t    i_imm, s_imm, b_imm;
  op_e      d_op;
  word_t    d_imm;
  logic     d_use_rs1, d_use_rs2, d_wen;

  assign d_opcode = fd_inst[6:0];
  assign d_rd     = fd_inst[11:7];
  assign d_f3     = fd_inst[14:12];
  assign d_rs1    = fd_inst[19:15];
  assign d_rs2    = fd_inst[24:20];
  assign d_f7     = fd_inst[31:25];

  assign i_imm = {{20{fd_inst[31]}}, fd_inst[31:20]};
  assign s_imm = {{20{fd_inst[31]}}, fd_inst[31:25], fd_inst[11:7]};
  assign b_imm = {{19{fd_inst[31]}}, fd_inst[31], fd_inst[7], fd_inst[30:25],
                  fd_inst[11:8], 1'b0};

  always_comb begin
    d_op      = DEC_NOP;
    d_imm     = i_imm;
    d_use_rs1 = 1'b0;
    d_use_rs2 = 1'b0;
    d_wen     = 1'b0;
    case (d_opcode)
      OP_IMM: if (d_f3 == F3_ADD) begin
        d_op      = DEC_ADDI;
        d_use_rs1 = 1'b1;
        d_wen     = 1'b1;
      end
      OP_REG: if (d_f3 == F3_ADD || d_f3 == F3_MUL) begin
        if (d_f7 == F7_ADD || d_f7 == F7_MUL) begin
          d_op      = (d_f7 == F7_MUL) ? DEC_MUL : DEC_ADD;
          d_use_rs1 = 1'b1;
          d_use_rs2 = 1'b1;
          d_wen     = 1'b1;
        end
      end
      OP_LOAD: if (d_f3 == F3_LW) begin
        d_op      = DEC_LW;
        d_use_rs1 = 1'b1;
        d_wen     = 1'b1;
      end
      OP_STORE: if (d_f3 == F3_SW) begin
        d_op      = DEC_SW;
        d_imm     = s_imm;
        d_use_rs1 = 1'b1;
        d_use_rs2 = 1'b1;
      end
      OP_BRANCH: if (d_f3 == F3_BNE) begin
        d_op      = DEC_BNE;
        d_imm     = b_imm;
        d_use_rs1 = 1'b1;
        d_use_rs2 = 1'b1;
      end
      default: ;
    endcase
  end

  // Register file read, W write passes straight through
  function automatic word_t rf_read(input reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end
    if (w_val && w_wen && idx == w_rd) begin
      return w_data;
    end
    return rf[idx];
  endfunction

  word_t d_a, d_b;

  assign d_a = rf_read(d_rs1);
  assign d_b = rf_read(d_rs2);

  // ======================================================================
  // Interlock and branch
  // ======================================================================

  logic x_hit, m_hit, hazard, m_stall, d_issue;

  assign x_hit = x_val && x_wen && (x_rd != '0);
  assign m_hit = m_val && m_wen && (m_rd != '0);

  assign hazard =
    (d_use_rs1 && ((x_hit && x_rd == d_rs1) || (m_hit && m_rd == d_rs1))) ||
    (d_use_rs2 && ((x_hit && x_rd == d_rs2) || (m_hit && m_rd == d_rs2)));

  // Data request refused, M holds
  assign m_stall = dmem_val && !dmem_gnt;
  assign stall_d = m_stall || (fd_val && hazard);
  assign d_issue = fd_val && !stall_d;

  assign redirect_val = d_issue && (d_op == DEC_BNE) && (d_a != d_b);
  assign redirect_pc  = fd_pc + d_imm;

  // ======================================================================
  // Execute
  // ======================================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      x_val <= 1'b0;
    end else if (!m_stall) begin
      x_val <= d_issue;
    end
  end

  always_ff @(posedge clk) begin
    if (!m_stall) begin
      x_op   <= d_op;
      x_pc   <= fd_pc;
      x_inst <= fd_inst;
      x_rd   <= d_rd;
      x_wen  <= d_wen;
      x_a    <= d_a;
      x_b    <= d_b;
      x_imm  <= d_imm;
    end
  end

  word_t x_result;

  always_comb begin
    case (x_op)
      DEC_ADD:                   x_result = x_a + x_b;
      DEC_MUL:                   x_result = x_a * x_b;
      DEC_ADDI, DEC_LW, DEC_SW:  x_result = x_a + x_imm;
      default:                   x_result = '0;
    endcase
  end

  // ======================================================================
  // Memory
  // ======================================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      m_val <= 1'b0;
    end else if (!m_stall) begin
      m_val <= x_val;
    end
  end

  always_ff @(posedge clk) begin
    if (!m_stall) begin
      m_op    <= x_op;
      m_pc    <= x_pc;
      m_inst  <= x_inst;
      m_rd    <= x_rd;
      m_wen   <= x_wen;
      m_alu   <= x_result;
      m_sdata <= x_b;
    end
  end

  assign dmem_val   = m_val && (m_op == DEC_LW || m_op == DEC_SW);
  assign dmem_we    = m_val && (m_op == DEC_SW);
  assign dmem_addr  = m_alu;
  assign dmem_wdata = m_sdata;

  word_t m_result;

  always_comb begin
    case (m_op)
      DEC_LW:  m_result = dmem_rdata;
      DEC_SW:  m_result = m_sdata;
      DEC_BNE: m_result = '0;
      default: m_result = m_alu;
    endcase
  end

  // ======================================================================
  // Writeback and trace
  // ======================================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      w_val <= 1'b0;
    end else begin
      w_val <= m_val && !m_stall;
    end
  end

  always_ff @(posedge clk) begin
    w_pc   <= m_pc;
    w_inst <= m_inst;
    w_rd   <= m_rd;
    w_wen  <= m_wen;
    w_data <= m_result;
  end

  always_ff @(posedge clk) begin
    if (w_val && w_wen && w_rd != '0) begin
      rf[w_rd] <= w_data;
    end
  end

  assign trace_val  = w_val;
  assign trace_addr = w_pc;
  assign trace_inst = w_inst;
  assign trace_data = w_data;

  assert property (@(posedge clk) disable iff (rst) trace_val |-> !$isunknown(trace_data))
    else $error("retired instruction has unknown trace_data");

  assert property (@(posedge clk) disable iff (rst) dmem_val |-> dmem_addr[1:0] == 2'b00)
    else $error("misaligned data address %h", dmem_addr);

endmodule

/* proc/proc_fetch.sv */
`timescale 1ns/1ps

module proc_fetch (
  input  logic                clk,
  input  logic                rst,
  input  logic                stall_d,
  input  logic                redirect_val,
  input  tinyrv1_pkg::addr_t  redirect_pc,
  input  logic                imem_gnt,
  input  tinyrv1_pkg::word_t  imem_rdata,
  output logic                imem_val,
  output tinyrv1_pkg::addr_t  imem_addr,
  output logic                fd_val,
  output tinyrv1_pkg::addr_t  fd_pc,
  output tinyrv1_pkg::word_t  fd_inst
);

  import tinyrv1_pkg::*;

  addr_t pc;
  logic  req_on;

  // Request every cycle once out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      req_on <= 1'b0;
    end else begin
      req_on <= 1'b1;
    end
  end

  assign imem_val  = req_on;
  assign imem_addr = pc;

  // ======================================================================
  // PC and F/D register
  // ======================================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      pc     <= RESET_PC;
      fd_val <= 1'b0;
    end else if (redirect_val) begin
      // Taken bne: drop the wrong-path fetch
      pc     <= redirect_pc;
      fd_val <= 1'b0;
    end else if (!stall_d) begin
      fd_val <= imem_gnt;
      if (imem_gnt) begin
        pc <= pc + INST_BYTES;
      end
    end
  end

  // Payload only
  always_ff @(posedge clk) begin
    if (!stall_d && imem_gnt) begin
      fd_pc   <= pc;
      fd_inst <= imem_rdata;
    end
  end

  // A valid F/D entry must come from a granted fetch
  assert property (@(posedge clk) disable iff (rst) $rose(fd_val) |-> $past(imem_gnt))
    else $error("fd_val rose without an instruction grant");

endmodule

/* common/mem_sys_pkg.sv */
package mem_sys_pkg;

  // ======================================================================
  // Shared memory system
  // ======================================================================

  // Widest word index the memory port can carry
  localparam int MEM_IDX_W = 16;

  // Word index; upper bits beyond the module's MEM_AW stay zero
  typedef logic [MEM_IDX_W-1:0] mem_idx_t;

  // Arbiter winner, listed in priority order
  typedef enum logic [1:0] {
    SRC_HOST  = 2'd0,
    SRC_DATA  = 2'd1,
    SRC_FETCH = 2'd2,
    SRC_NONE  = 2'd3
  } req_src_e;

endpackage

/* common/tinyrv1_pkg.sv */
package tinyrv1_pkg;

  // ======================================================================
  // Widths
  // ======================================================================

  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0]             word_t;
  typedef logic [31:0]                 addr_t;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // Start address after reset
  localparam addr_t RESET_PC = 32'h0000_0000;

  // Byte step between instructions
  localparam addr_t INST_BYTES = 32'd4;

  // ======================================================================
  // Major opcodes (standard RV32 encodings)
  // ======================================================================

  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_REG    = 7'b0110011;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_BRANCH = 7'b1100011;

  // funct3 values
  localparam funct3_t F3_ADD = 3'b000;
  localparam funct3_t F3_MUL = 3'b000;
  localparam funct3_t F3_LW  = 3'b010;
  localparam funct3_t F3_SW  = 3'b010;
  localparam funct3_t F3_BNE = 3'b001;

  // funct7 values, add vs. the M extension
  localparam funct7_t F7_ADD = 7'b0000000;
  localparam funct7_t F7_MUL = 7'b0000001;

endpackage
